// ==== design/lsu_pkg.sv ====
package lsu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [1:0]  csr_idx_t;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  typedef enum logic [1:0] {
    LOAD_BYTE = 2'd0,
    LOAD_HALF = 2'd1,
    LOAD_WORD = 2'd2
  } load_size_e;

  typedef enum logic [1:0] {
    WD_ALU  = 2'd0,
    WD_LOAD = 2'd1,
    WD_PC4  = 2'd2,
    WD_SRC2 = 2'd3
  } wd_op_e;

  typedef enum logic {
    CSR_WD_ALU = 1'b0,
    CSR_WD_PC  = 1'b1
  } csr_wd_op_e;

  typedef enum logic [2:0] {
    ST_IDLE       = 3'd0,
    ST_READ_ADDR  = 3'd1,
    ST_READ_DATA  = 3'd2,
    ST_WRITE_ADDR = 3'd3,
    ST_WRITE_RESP = 3'd4,
    ST_REPORT     = 3'd5
  } lsu_state_e;

  typedef struct packed {
    logic       ren;
    logic       wen;
    logic       load_signed;
    load_size_e load_size;
    strb_t      wstrb;
    word_t      alu_result;     // Also the memory address.
    word_t      pc;
    word_t      pc_next;
    word_t      instruction;
    word_t      src2;
    word_t      store_data;     // Already aligned to the byte lanes.
    wd_op_e     wd_op;
    csr_wd_op_e csr_wd_op;
    reg_idx_t   rd;
    csr_idx_t   csr_rd;
    logic       reg_write_en;
    logic       csreg_write_en;
    logic       ecall;
  } exu_bundle_t;

  typedef struct packed {
    word_t    wd;
    word_t    csr_wd;
    reg_idx_t rd;
    csr_idx_t csr_rd;
    word_t    pc;
    word_t    pc_next;
    word_t    instruction;
    logic     reg_write_en;
    logic     csreg_write_en;
    logic     ecall;
  } wbu_bundle_t;

  typedef struct packed {
    word_t araddr;
    logic  arvalid;
    logic  rready;
    word_t awaddr;
    logic  awvalid;
    word_t wdata;
    strb_t wstrb;
    logic  wvalid;
    logic  bready;
  } axi_req_t;

  typedef struct packed {
    logic       arready;
    word_t      rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
  } axi_rsp_t;

endpackage

// ==== design/lsu.sv ====
module lsu import lsu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        exu_valid,
  input  exu_bundle_t exu_in,
  input  axi_rsp_t    axi_rsp,
  output axi_req_t    axi_req,
  output exu_bundle_t captured,
  output word_t       load_raw,
  output logic        wb_valid,
  output logic        busy
);

  lsu_state_e state_q;
  lsu_state_e state_d;
  logic       arvalid_q;
  logic       awvalid_q;
  logic       wvalid_q;
  logic       ready_q;
  logic       accept;
  logic       ar_fire;
  logic       r_fire;
  logic       aw_fire;
  logic       w_fire;
  logic       b_fire;
  logic       aw_left;
  logic       w_left;

  assign accept  = (state_q == ST_IDLE) && exu_valid;
  assign ar_fire = arvalid_q && axi_rsp.arready;
  assign aw_fire = awvalid_q && axi_rsp.awready;
  assign w_fire  = wvalid_q && axi_rsp.wready;
  assign r_fire  = (state_q == ST_READ_DATA) && ready_q && axi_rsp.rvalid;
  assign b_fire  = (state_q == ST_WRITE_RESP) && ready_q && axi_rsp.bvalid;

  // Channels still open after this edge.
  assign aw_left = awvalid_q && !aw_fire;
  assign w_left  = wvalid_q && !w_fire;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (exu_valid) begin
          if (exu_in.ren) begin
            state_d = ST_READ_ADDR;
          end else if (exu_in.wen) begin
            state_d = ST_WRITE_ADDR;
          end else begin
            state_d = ST_REPORT;
          end
        end
      end
      ST_READ_ADDR: begin
        if (ar_fire) begin
          state_d = ST_READ_DATA;
        end
      end
      ST_READ_DATA: begin
        if (r_fire) begin
          state_d = ST_REPORT;
        end
      end
      ST_WRITE_ADDR: begin
        if (!aw_left && !w_left) begin
          state_d = ST_WRITE_RESP;
        end
      end
      ST_WRITE_RESP: begin
        if (b_fire) begin
          state_d = ST_REPORT;
        end
      end
      ST_REPORT: state_d = ST_IDLE;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= ST_IDLE;
      arvalid_q <= 1'b0;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      ready_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ready_q <= 1'b1;
      if (accept && exu_in.ren) begin
        arvalid_q <= 1'b1;
      end else if (ar_fire) begin
        arvalid_q <= 1'b0;
      end
      if (accept && !exu_in.ren && exu_in.wen) begin
        awvalid_q <= 1'b1;
        wvalid_q  <= 1'b1;
      end else begin
        if (aw_fire) begin
          awvalid_q <= 1'b0;
        end
        if (w_fire) begin
          wvalid_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      captured <= exu_in;
    end
    if (r_fire) begin
      load_raw <= axi_rsp.rdata;
    end
  end

  assign axi_req = '{
    araddr:  captured.alu_result,
    arvalid: arvalid_q,
    rready:  ready_q,
    awaddr:  captured.alu_result,
    awvalid: awvalid_q,
    wdata:   captured.store_data,
    wstrb:   captured.wstrb,
    wvalid:  wvalid_q,
    bready:  ready_q
  };

  assign wb_valid = (state_q == ST_REPORT);
  assign busy     = (state_q != ST_IDLE);

  property valid_held(logic valid, logic ready);
    @(posedge clk) disable iff (rst) valid && !ready |=> valid;
  endproperty

  a_no_read_write_overlap: assert property (
    @(posedge clk) disable iff (rst) !(axi_req.arvalid && axi_req.awvalid));

  a_wb_valid_pulse: assert property (
    @(posedge clk) disable iff (rst) wb_valid |=> !wb_valid);

  a_arvalid_held: assert property (valid_held(axi_req.arvalid, axi_rsp.arready));
  a_awvalid_held: assert property (valid_held(axi_req.awvalid, axi_rsp.awready));
  a_wvalid_held:  assert property (valid_held(axi_req.wvalid, axi_rsp.wready));

endmodule

// ==== design/wb_select.sv ====
module wb_select import lsu_pkg::*; (
  input  exu_bundle_t captured,
  input  word_t       load_raw,
  output word_t       wd,
  output word_t       csr_wd
);

  word_t shifted;
  word_t load_data;
  word_t pc_plus4;

  // Byte lane of the access moves down to bit 0.
  assign shifted  = load_raw >> {captured.alu_result[1:0], 3'b000};
  assign pc_plus4 = captured.pc + 32'd4;

  always_comb begin
    case (captured.load_size)
      LOAD_BYTE: begin
        if (captured.load_signed) begin
          load_data = {{24{shifted[7]}}, shifted[7:0]};
        end else begin
          load_data = {24'd0, shifted[7:0]};
        end
      end
      LOAD_HALF: begin
        if (captured.load_signed) begin
          load_data = {{16{shifted[15]}}, shifted[15:0]};
        end else begin
          load_data = {16'd0, shifted[15:0]};
        end
      end
      default: load_data = shifted;
    endcase
  end

  always_comb begin
    case (captured.wd_op)
      WD_ALU:  wd = captured.alu_result;
      WD_LOAD: wd = load_data;
      WD_PC4:  wd = pc_plus4;
      WD_SRC2: wd = captured.src2;
      default: wd = captured.alu_result;
    endcase
  end

  always_comb begin
    case (captured.csr_wd_op)
      CSR_WD_PC: csr_wd = captured.pc;
      default:   csr_wd = captured.alu_result;
    endcase
  end

endmodule

// ==== design/axi_lite_sram.sv ====
module axi_lite_sram import lsu_pkg::*; #(
  parameter int DEPTH_WORDS = 256,
  parameter int WAIT_STATES = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  axi_req_t axi_req,
  output axi_rsp_t axi_rsp
);

  localparam int IDX_W = $clog2(DEPTH_WORDS);
  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
  localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(WAIT_STATES);

  word_t            mem [DEPTH_WORDS];
  logic [CNT_W-1:0] wait_cnt [3];
  logic [2:0]       chan_valid;          // Index 0 is ar, 1 is aw, 2 is w.
  logic [2:0]       chan_open;
  logic [2:0]       chan_ready;
  logic             aw_held;
  logic             w_held;
  logic             aw_have;
  logic             w_have;
  logic             commit;
  logic             rvalid_q;
  logic             bvalid_q;
  word_t            rdata_q;
  word_t            aw_addr_q;
  word_t            w_data_q;
  strb_t            w_strb_q;
  word_t            wr_addr;
  word_t            wr_data;
  strb_t            wr_strb;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  logic             aw_seen;             // Bus aw handshake since the last b handshake.
  logic             w_seen;

  assign chan_valid = {axi_req.wvalid, axi_req.awvalid, axi_req.arvalid};
  assign chan_open  = {!w_held && !bvalid_q, !aw_held && !bvalid_q, !rvalid_q};

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      chan_ready[i] = chan_valid[i] && chan_open[i] && (wait_cnt[i] == WAIT_LAST);
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      if (rst || !chan_valid[i] || chan_ready[i]) begin
        wait_cnt[i] <= '0;
      end else if (wait_cnt[i] != WAIT_LAST) begin
        wait_cnt[i] <= wait_cnt[i] + 1'b1;
      end
    end
  end

  // Address and data may land on the same edge or apart.
  assign aw_have = aw_held || chan_ready[1];
  assign w_have  = w_held || chan_ready[2];
  assign commit  = aw_have && w_have;
  assign wr_addr = aw_held ? aw_addr_q : axi_req.awaddr;
  assign wr_data = w_held ? w_data_q : axi_req.wdata;
  assign wr_strb = w_held ? w_strb_q : axi_req.wstrb;
  assign wr_idx  = wr_addr[2 +: IDX_W];   // Wraps inside the depth.
  assign rd_idx  = axi_req.araddr[2 +: IDX_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (bvalid_q && axi_req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (commit) begin
        aw_held  <= 1'b0;
        w_held   <= 1'b0;
        bvalid_q <= 1'b1;
      end else begin
        if (chan_ready[1]) begin
          aw_held <= 1'b1;
        end
        if (chan_ready[2]) begin
          w_held <= 1'b1;
        end
      end
      if (chan_ready[0]) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && axi_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (chan_ready[1]) begin
      aw_addr_q <= axi_req.awaddr;
    end
    if (chan_ready[2]) begin
      w_data_q <= axi_req.wdata;
      w_strb_q <= axi_req.wstrb;
    end
    if (commit) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_strb[b]) begin
          mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
        end
      end
    end
    if (chan_ready[0]) begin
      rdata_q <= mem[rd_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (rst || (axi_rsp.bvalid && axi_req.bready)) begin
      aw_seen <= 1'b0;
      w_seen  <= 1'b0;
    end else begin
      if (axi_req.awvalid && axi_rsp.awready) begin
        aw_seen <= 1'b1;
      end
      if (axi_req.wvalid && axi_rsp.wready) begin
        w_seen <= 1'b1;
      end
    end
  end

  assign axi_rsp = '{
    arready: chan_ready[0],
    rdata:   rdata_q,
    rresp:   AXI_RESP_OKAY,
    rvalid:  rvalid_q,
    awready: chan_ready[1],
    wready:  chan_ready[2],
    bvalid:  bvalid_q,
    bresp:   AXI_RESP_OKAY
  };

  a_bvalid_after_aw_w: assert property (
    @(posedge clk) disable iff (rst) $rose(axi_rsp.bvalid) |-> aw_seen && w_seen);

endmodule

// ==== design/mem_stage_top.sv ====
module mem_stage_top import lsu_pkg::*; #(
  parameter int DEPTH_WORDS = 256,
  parameter int WAIT_STATES = 2
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        exu_valid,
  input  exu_bundle_t exu_in,
  output logic        wb_valid,
  output wbu_bundle_t wb_out,
  output logic        busy
);

  axi_req_t    axi_req;
  axi_rsp_t    axi_rsp;
  exu_bundle_t captured;
  word_t       load_raw;
  word_t       wd;
  word_t       csr_wd;

  lsu u_lsu (
    .clk       (clk),
    .rst       (rst),
    .exu_valid (exu_valid),
    .exu_in    (exu_in),
    .axi_rsp   (axi_rsp),
    .axi_req   (axi_req),
    .captured  (captured),
    .load_raw  (load_raw),
    .wb_valid  (wb_valid),
    .busy      (busy)
  );

  wb_select u_wb_select (
    .captured (captured),
    .load_raw (load_raw),
    .wd       (wd),
    .csr_wd   (csr_wd)
  );

  axi_lite_sram #(
    .DEPTH_WORDS (DEPTH_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) u_sram (
    .clk     (clk),
    .rst     (rst),
    .axi_req (axi_req),
    .axi_rsp (axi_rsp)
  );

  assign wb_out = '{
    wd:             wd,
    csr_wd:         csr_wd,
    rd:             captured.rd,
    csr_rd:         captured.csr_rd,
    pc:             captured.pc,
    pc_next:        captured.pc_next,
    instruction:    captured.instruction,
    reg_write_en:   captured.reg_write_en,
    csreg_write_en: captured.csreg_write_en,
    ecall:          captured.ecall
  };

endmodule

// ==== bench/mem_stage_tb.sv ====
module mem_stage_tb import lsu_pkg::*; ();

  localparam int N_FILL  = 64;
  localparam int N_WORD  = 8;
  localparam int N_PART  = 8;
  localparam int N_EXT   = 4;
  localparam int N_OTHER = 50;
  localparam int N_MIXED = 300;
  localparam int TOTAL   = 1 + N_FILL + 2 * N_WORD + 4 * N_PART + 15 * N_EXT
                           + N_OTHER + N_MIXED;
  localparam int LIMIT   = 20 * TOTAL + 100;

  logic        clk;
  logic        rst;
  logic        exu_valid;
  exu_bundle_t exu_in;
  logic        wb_valid;
  wbu_bundle_t wb_out;
  logic        busy;

  word_t       rng;
  word_t       ref_mem [256];
  exu_bundle_t pending;        // Instruction accepted and not yet reported.
  logic        in_flight;
  int          age;
  int          errors;
  int          reports;
  int          issued;
  int          cycles;

  mem_stage_top #(
    .DEPTH_WORDS (256),
    .WAIT_STATES (2)
  ) uut (
    .clk       (clk),
    .rst       (rst),
    .exu_valid (exu_valid),
    .exu_in    (exu_in),
    .wb_valid  (wb_valid),
    .wb_out    (wb_out),
    .busy      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic word_t next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic word_t rand_addr();
    word_t r;
    r = next_rand();
    return {24'd0, r[5:0], 2'b00};   // First 64 words only.
  endfunction

  function automatic exu_bundle_t base_bundle();
    exu_bundle_t b;
    word_t       r;
    int          sel;
    b = '0;
    b.alu_result     = next_rand();
    b.pc             = next_rand() & 32'hffff_fffc;
    b.pc_next        = next_rand();
    b.instruction    = next_rand();
    b.src2           = next_rand();
    r                = next_rand();
    b.rd             = r[4:0];
    b.csr_rd         = r[6:5];
    b.reg_write_en   = r[7];
    b.csreg_write_en = r[8];
    b.ecall          = r[9];
    b.load_signed    = r[10];
    b.csr_wd_op      = csr_wd_op_e'(r[11]);
    b.load_size      = LOAD_WORD;
    sel = int'(r[31:16]) % 3;
    case (sel)
      0:       b.wd_op = WD_ALU;
      1:       b.wd_op = WD_PC4;
      default: b.wd_op = WD_SRC2;
    endcase
    return b;
  endfunction

  function automatic exu_bundle_t load_op(word_t addr, load_size_e size, logic sgn);
    exu_bundle_t b;
    b = base_bundle();
    b.ren         = 1'b1;
    b.alu_result  = addr;
    b.load_size   = size;
    b.load_signed = sgn;
    b.wd_op       = WD_LOAD;
    return b;
  endfunction

  function automatic exu_bundle_t store_op(word_t addr, strb_t strb, word_t data);
    exu_bundle_t b;
    b = base_bundle();
    b.wen        = 1'b1;
    b.alu_result = addr;
    b.wstrb      = strb;
    b.store_data = data;
    return b;
  endfunction

  // Byte or halfword store with the data already in its lanes.
  function automatic exu_bundle_t rand_store();
    word_t r;
    r = next_rand();
    if (r[2]) begin
      return store_op(rand_addr() | word_t'({r[1], 1'b0}), r[1] ? 4'b1100 : 4'b0011,
                      next_rand());
    end
    return store_op(rand_addr() | word_t'(r[1:0]), strb_t'(4'b0001 << r[1:0]), next_rand());
  endfunction

  function automatic exu_bundle_t rand_load();
    word_t r;
    int    sel;
    r = next_rand();
    sel = int'(r[1:0]) % 3;
    case (sel)
      0:       return load_op(rand_addr() | word_t'(r[3:2]), LOAD_BYTE, r[4]);
      1:       return load_op(rand_addr() | word_t'({r[3], 1'b0}), LOAD_HALF, r[4]);
      default: return load_op(rand_addr(), LOAD_WORD, r[4]);
    endcase
  endfunction

  function automatic word_t expect_load(word_t mem_word, logic [1:0] off, load_size_e size,
                                        logic sgn);
    word_t w;
    w = mem_word >> (8 * int'(off));
    case (size)
      LOAD_BYTE: return sgn ? {{24{w[7]}}, w[7:0]} : {24'd0, w[7:0]};
      LOAD_HALF: return sgn ? {{16{w[15]}}, w[15:0]} : {16'd0, w[15:0]};
      default:   return w;
    endcase
  endfunction

  function automatic word_t expect_wd(exu_bundle_t b);
    case (b.wd_op)
      WD_ALU:  return b.alu_result;
      WD_LOAD: return expect_load(ref_mem[b.alu_result[9:2]], b.alu_result[1:0],
                                  b.load_size, b.load_signed);
      WD_PC4:  return b.pc + 32'd4;
      default: return b.src2;
    endcase
  endfunction

  task automatic apply_store(exu_bundle_t b);
    for (int i = 0; i < 4; i++) begin
      if (b.wstrb[i]) begin
        ref_mem[b.alu_result[9:2]][i*8 +: 8] = b.store_data[i*8 +: 8];
      end
    end
  endtask

  task automatic check_report();
    word_t       exp_wd;
    word_t       exp_csr;
    wbu_bundle_t got_side;
    wbu_bundle_t exp_side;
    exp_wd  = expect_wd(pending);
    exp_csr = (pending.csr_wd_op == CSR_WD_PC) ? pending.pc : pending.alu_result;
    exp_side = '{wd: '0, csr_wd: '0, rd: pending.rd, csr_rd: pending.csr_rd, pc: pending.pc,
                 pc_next: pending.pc_next, instruction: pending.instruction,
                 reg_write_en: pending.reg_write_en, csreg_write_en: pending.csreg_write_en,
                 ecall: pending.ecall};
    got_side        = wb_out;
    got_side.wd     = '0;
    got_side.csr_wd = '0;
    assert (wb_out.wd === exp_wd) else begin
      errors++;
      $display("error %0t: wd is %h, expected %h (wd_op %0d)", $time, wb_out.wd, exp_wd,
               pending.wd_op);
    end
    assert (wb_out.csr_wd === exp_csr) else begin
      errors++;
      $display("error %0t: csr_wd is %h, expected %h", $time, wb_out.csr_wd, exp_csr);
    end
    assert (got_side === exp_side) else begin
      errors++;
      $display("error %0t: sideband fields differ from the accepted instruction", $time);
    end
    if (!pending.ren && !pending.wen) begin
      assert (age == 1) else begin
        errors++;
        $display("error %0t: non-memory report came %0d cycles after acceptance", $time, age);
      end
    end
    if (pending.wen) begin
      apply_store(pending);
    end
    reports++;
  endtask

  // Outputs are sampled mid-cycle away from the clock and input edges.
  always @(negedge clk) begin
    if (!rst) begin
      if (in_flight) begin
        age++;
        assert (busy) else begin
          errors++;
          $display("error %0t: busy low while an instruction is in flight", $time);
        end
        if (wb_valid) begin
          check_report();
          in_flight = 1'b0;
        end
      end else begin
        assert (!wb_valid) else begin
          errors++;
          $display("error %0t: wb_valid with no instruction in flight", $time);
        end
        assert (!busy) else begin
          errors++;
          $display("error %0t: busy high with no instruction in flight", $time);
        end
        if (exu_valid) begin
          in_flight = 1'b1;
          age       = 0;
          pending   = exu_in;
        end
      end
    end
  end

  // Called just after a rising edge with busy low.
  task automatic issue(exu_bundle_t b);
    exu_in    = b;
    exu_valid = 1'b1;
    issued++;
    @(posedge clk);
    #10;
    exu_valid = 1'b0;
    while (busy) begin
      @(posedge clk);
      #10;
    end
  endtask

  initial begin
    word_t addr;
    word_t r;
    rst       = 1'b1;
    exu_valid = 1'b0;
    exu_in    = '0;
    rng       = 32'd88;
    in_flight = 1'b0;
    age       = 0;
    errors    = 0;
    reports   = 0;
    issued    = 0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = '0;
    end
    repeat (3) @(posedge clk);
    #10;
    rst = 1'b0;
    repeat (5) @(posedge clk);   // Nothing may report while idle.
    #10;
    issue(base_bundle());
    for (int i = 0; i < N_FILL; i++) begin
      issue(store_op(word_t'(i) << 2, 4'hf, word_t'(i) * 32'h9e37_79b1 ^ 32'h5ac3_3ca5));
    end
    for (int i = 0; i < N_WORD; i++) begin
      addr = rand_addr();
      issue(store_op(addr, 4'hf, next_rand()));
      issue(load_op(addr, LOAD_WORD, 1'b0));
    end
    for (int i = 0; i < N_PART; i++) begin
      addr = rand_addr();
      r = next_rand();
      issue(store_op(addr | word_t'(r[1:0]), strb_t'(4'b0001 << r[1:0]), next_rand()));
      issue(load_op(addr, LOAD_WORD, 1'b0));
      issue(store_op(addr | word_t'({r[2], 1'b0}), r[2] ? 4'b1100 : 4'b0011, next_rand()));
      issue(load_op(addr, LOAD_WORD, 1'b0));
    end
    for (int k = 0; k < N_EXT; k++) begin
      addr = rand_addr();
      r = (next_rand() & 32'h7f7f_7f7f) | (k[0] ? 32'h8000_8000 : 32'h0080_0080);
      issue(store_op(addr, 4'hf, r));
      for (int off = 0; off < 4; off++) begin
        for (int sgn = 0; sgn < 2; sgn++) begin
          issue(load_op(addr | word_t'(off), LOAD_BYTE, sgn == 1));
        end
      end
      for (int off = 0; off < 3; off++) begin
        for (int sgn = 0; sgn < 2; sgn++) begin
          issue(load_op(addr | word_t'(off), LOAD_HALF, sgn == 1));
        end
      end
    end
    for (int i = 0; i < N_OTHER; i++) begin
      r = next_rand();
      issue(r[0] ? rand_store() : base_bundle());
    end
    for (int i = 0; i < N_MIXED; i++) begin
      r = next_rand();
      case (r[1:0])
        2'd0:    issue(base_bundle());
        2'd1:    issue(rand_load());
        2'd2:    issue(store_op(rand_addr(), 4'hf, next_rand()));
        default: issue(rand_store());
      endcase
    end
    repeat (5) @(posedge clk);
    assert (!in_flight && reports == issued) else begin
      errors++;
      $display("error %0t: %0d instructions issued, %0d reports seen", $time,
               issued, reports);
    end
    $display("%0d errors, %0d of %0d instructions reported", errors, reports, issued);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run still going after %0d cycles", LIMIT);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== mem_stage_top.f ====
design/lsu_pkg.sv
design/lsu.sv
design/wb_select.sv
design/axi_lite_sram.sv
design/mem_stage_top.sv
bench/mem_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
RTL_TOP   ?= mem_stage_top
TB_TOP    ?= mem_stage_tb
FILELIST  ?= mem_stage_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: lint sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --assert --timing $(VFLAGS) -f $(FILELIST) \
	  --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -o V$(TB_TOP)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
